/* core_bus_pkg.sv */
package core_bus_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;  // one bit per data byte
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;   // beats minus one
  typedef logic [1:0]  resp_t;

  localparam resp_t resp_okay = 2'b00;

  // clint window, both ends inclusive
  localparam addr_t clint_base = 32'h0200_0000;
  localparam addr_t clint_last = 32'h0200_ffff;

  localparam logic [15:0] mtimecmp_off = 16'h4000;
  localparam logic [15:0] mtime_off    = 16'hbff8;

  typedef enum logic [2:0] {
    idle,
    ifu_read,
    exu_read,
    exu_write,
    clint_read,
    clint_write
  } grant_t;

endpackage

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                clock,
  input  logic                reset,
  // ifu, read only
  input  logic                ifu_arvalid_i, ifu_rready_i,
  output logic                ifu_arready_o, ifu_rvalid_o, ifu_rlast_o,
  input  core_bus_pkg::addr_t ifu_araddr_i,
  input  core_bus_pkg::id_t   ifu_arid_i,
  input  core_bus_pkg::len_t  ifu_arlen_i,
  input  logic [2:0]          ifu_arsize_i,
  input  logic [1:0]          ifu_arburst_i,
  output core_bus_pkg::data_t ifu_rdata_o,
  output core_bus_pkg::resp_t ifu_rresp_o,
  output core_bus_pkg::id_t   ifu_rid_o,
  // exu, read and write
  input  logic                exu_arvalid_i, exu_rready_i,
  output logic                exu_arready_o, exu_rvalid_o, exu_rlast_o,
  input  core_bus_pkg::addr_t exu_araddr_i, exu_awaddr_i,
  input  core_bus_pkg::id_t   exu_arid_i, exu_awid_i,
  input  core_bus_pkg::len_t  exu_arlen_i, exu_awlen_i,
  input  logic [2:0]          exu_arsize_i, exu_awsize_i,
  input  logic [1:0]          exu_arburst_i, exu_awburst_i,
  output core_bus_pkg::data_t exu_rdata_o,
  output core_bus_pkg::resp_t exu_rresp_o, exu_bresp_o,
  output core_bus_pkg::id_t   exu_rid_o, exu_bid_o,
  input  logic                exu_awvalid_i, exu_wvalid_i, exu_wlast_i, exu_bready_i,
  output logic                exu_awready_o, exu_wready_o, exu_bvalid_o,
  input  core_bus_pkg::data_t exu_wdata_i,
  input  core_bus_pkg::strb_t exu_wstrb_i,
  // shared axi4 port
  output logic                m_arvalid_o, m_rready_o, m_awvalid_o, m_wvalid_o, m_wlast_o,
  output logic                m_bready_o,
  input  logic                m_arready_i, m_rvalid_i, m_rlast_i, m_awready_i, m_wready_i,
  input  logic                m_bvalid_i,
  output core_bus_pkg::addr_t m_araddr_o, m_awaddr_o,
  output core_bus_pkg::id_t   m_arid_o, m_awid_o,
  output core_bus_pkg::len_t  m_arlen_o, m_awlen_o,
  output logic [2:0]          m_arsize_o, m_awsize_o,
  output logic [1:0]          m_arburst_o, m_awburst_o,
  output core_bus_pkg::data_t m_wdata_o,
  output core_bus_pkg::strb_t m_wstrb_o,
  input  core_bus_pkg::data_t m_rdata_i,
  input  core_bus_pkg::resp_t m_rresp_i, m_bresp_i,
  input  core_bus_pkg::id_t   m_rid_i, m_bid_i,
  // clint link, single beats
  output logic                clint_arvalid_o, clint_rready_o, clint_awvalid_o,
  output logic                clint_wvalid_o, clint_bready_o,
  input  logic                clint_arready_i, clint_rvalid_i, clint_awready_i,
  input  logic                clint_wready_i, clint_bvalid_i,
  output core_bus_pkg::addr_t clint_araddr_o, clint_awaddr_o,
  output core_bus_pkg::data_t clint_wdata_o,
  output core_bus_pkg::strb_t clint_wstrb_o,
  input  core_bus_pkg::data_t clint_rdata_i,
  input  core_bus_pkg::resp_t clint_rresp_i
);

  import core_bus_pkg::*;

  grant_t grant;
  id_t    clint_id_q;  // echoed as rid/bid on the clint path
  logic   ar_in_clint;
  logic   aw_in_clint;
  logic   done;        // final transfer of the granted access
  logic   sel_ifu, sel_exu_rd, sel_exu_wr, sel_clint_rd, sel_clint_wr;

  assign ar_in_clint  = (exu_araddr_i >= clint_base) && (exu_araddr_i <= clint_last);
  assign aw_in_clint  = (exu_awaddr_i >= clint_base) && (exu_awaddr_i <= clint_last);
  assign sel_ifu      = grant == ifu_read;
  assign sel_exu_rd   = grant == exu_read;
  assign sel_exu_wr   = grant == exu_write;
  assign sel_clint_rd = grant == clint_read;
  assign sel_clint_wr = grant == clint_write;

  always_comb begin
    case (grant)
      ifu_read:    done = m_rvalid_i && ifu_rready_i && m_rlast_i;
      exu_read:    done = m_rvalid_i && exu_rready_i && m_rlast_i;
      exu_write:   done = m_bvalid_i && exu_bready_i;
      clint_read:  done = clint_rvalid_i && exu_rready_i;
      clint_write: done = clint_bvalid_i && exu_bready_i;
      default:     done = 1'b0;
    endcase
  end

  // exu read, then exu write, then ifu read
  always_ff @(posedge clock) begin
    if (reset) begin
      grant <= idle;
    end else if (grant == idle) begin
      if (exu_arvalid_i) begin
        grant <= ar_in_clint ? clint_read : exu_read;
      end else if (exu_awvalid_i) begin
        grant <= aw_in_clint ? clint_write : exu_write;
      end else if (ifu_arvalid_i) begin
        grant <= ifu_read;
      end
    end else if (done) begin
      grant <= idle;
    end
  end

  always_ff @(posedge clock) begin
    if (grant == idle) begin
      clint_id_q <= exu_arvalid_i ? exu_arid_i : exu_awid_i;
    end
  end

  // shared port
  assign m_arvalid_o = (sel_ifu && ifu_arvalid_i) || (sel_exu_rd && exu_arvalid_i);
  assign m_araddr_o  = sel_ifu ? ifu_araddr_i  : (sel_exu_rd ? exu_araddr_i  : '0);
  assign m_arid_o    = sel_ifu ? ifu_arid_i    : (sel_exu_rd ? exu_arid_i    : '0);
  assign m_arlen_o   = sel_ifu ? ifu_arlen_i   : (sel_exu_rd ? exu_arlen_i   : '0);
  assign m_arsize_o  = sel_ifu ? ifu_arsize_i  : (sel_exu_rd ? exu_arsize_i  : '0);
  assign m_arburst_o = sel_ifu ? ifu_arburst_i : (sel_exu_rd ? exu_arburst_i : '0);
  assign m_rready_o  = (sel_ifu && ifu_rready_i) || (sel_exu_rd && exu_rready_i);
  assign m_awvalid_o = sel_exu_wr && exu_awvalid_i;
  assign m_awaddr_o  = sel_exu_wr ? exu_awaddr_i  : '0;
  assign m_awid_o    = sel_exu_wr ? exu_awid_i    : '0;
  assign m_awlen_o   = sel_exu_wr ? exu_awlen_i   : '0;
  assign m_awsize_o  = sel_exu_wr ? exu_awsize_i  : '0;
  assign m_awburst_o = sel_exu_wr ? exu_awburst_i : '0;
  assign m_wvalid_o  = sel_exu_wr && exu_wvalid_i;
  assign m_wdata_o   = sel_exu_wr ? exu_wdata_i : '0;
  assign m_wstrb_o   = sel_exu_wr ? exu_wstrb_i : '0;
  assign m_wlast_o   = sel_exu_wr && exu_wlast_i;
  assign m_bready_o  = sel_exu_wr && exu_bready_i;

  // ifu side
  assign ifu_arready_o = sel_ifu && m_arready_i;
  assign ifu_rvalid_o  = sel_ifu && m_rvalid_i;
  assign ifu_rdata_o   = sel_ifu ? m_rdata_i : '0;
  assign ifu_rresp_o   = sel_ifu ? m_rresp_i : '0;
  assign ifu_rid_o     = sel_ifu ? m_rid_i   : '0;
  assign ifu_rlast_o   = sel_ifu && m_rlast_i;

  // exu side, from sram or clint
  assign exu_arready_o = (sel_exu_rd && m_arready_i) || (sel_clint_rd && clint_arready_i);
  assign exu_rvalid_o  = (sel_exu_rd && m_rvalid_i) || (sel_clint_rd && clint_rvalid_i);
  assign exu_rdata_o   = sel_exu_rd ? m_rdata_i : (sel_clint_rd ? clint_rdata_i : '0);
  assign exu_rresp_o   = sel_exu_rd ? m_rresp_i : (sel_clint_rd ? clint_rresp_i : '0);
  assign exu_rid_o     = sel_exu_rd ? m_rid_i   : (sel_clint_rd ? clint_id_q    : '0);
  assign exu_rlast_o   = (sel_exu_rd && m_rlast_i) || sel_clint_rd;  // clint beat is the last
  assign exu_awready_o = (sel_exu_wr && m_awready_i) || (sel_clint_wr && clint_awready_i);
  assign exu_wready_o  = (sel_exu_wr && m_wready_i) || (sel_clint_wr && clint_wready_i);
  assign exu_bvalid_o  = (sel_exu_wr && m_bvalid_i) || (sel_clint_wr && clint_bvalid_i);
  assign exu_bresp_o   = sel_exu_wr ? m_bresp_i : (sel_clint_wr ? resp_okay  : '0);
  assign exu_bid_o     = sel_exu_wr ? m_bid_i   : (sel_clint_wr ? clint_id_q : '0);

  // clint link
  assign clint_arvalid_o = sel_clint_rd && exu_arvalid_i;
  assign clint_araddr_o  = sel_clint_rd ? exu_araddr_i : '0;
  assign clint_rready_o  = sel_clint_rd && exu_rready_i;
  assign clint_awvalid_o = sel_clint_wr && exu_awvalid_i;
  assign clint_awaddr_o  = sel_clint_wr ? exu_awaddr_i : '0;
  assign clint_wvalid_o  = sel_clint_wr && exu_wvalid_i;
  assign clint_wdata_o   = sel_clint_wr ? exu_wdata_i : '0;
  assign clint_wstrb_o   = sel_clint_wr ? exu_wstrb_i : '0;
  assign clint_bready_o  = sel_clint_wr && exu_bready_i;

  // an ifu beat needs the grant from before its address phase
  a_ifu_r_granted: assert property (@(posedge clock) disable iff (reset)
    ifu_rvalid_o |-> $past(grant) == ifu_read);

  // no response may still be pending once the grant is released
  a_idle_quiet: assert property (@(posedge clock) disable iff (reset)
    grant == idle |-> !m_rvalid_i && !m_bvalid_i && !clint_rvalid_i && !clint_bvalid_i);

endmodule

/* clint.sv */
`timescale 1ns/1ps

module clint (
  input  logic                clock,
  input  logic                reset,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  core_bus_pkg::addr_t araddr_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output core_bus_pkg::data_t rdata_o,
  output core_bus_pkg::resp_t rresp_o,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  core_bus_pkg::addr_t awaddr_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  core_bus_pkg::data_t wdata_i,
  input  core_bus_pkg::strb_t wstrb_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output logic                timer_irq_o
);

  import core_bus_pkg::*;

  data_t mtime;
  data_t mtimecmp;
  logic  wr_fire;

  assign arready_o   = !rvalid_o;  // one read in flight
  assign awready_o   = wvalid_i && !bvalid_o;  // aw and w taken in the same cycle
  assign wready_o    = awvalid_i && !bvalid_o;
  assign wr_fire     = awvalid_i && wvalid_i && !bvalid_o;
  assign rresp_o     = resp_okay;
  assign timer_irq_o = mtime >= mtimecmp;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime    <= '0;
      mtimecmp <= '1;  // no interrupt until software sets a compare value
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (arvalid_i && arready_o) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (wr_fire && awaddr_i[15:0] == mtimecmp_off) begin
        for (int b = 0; b < 8; b++) begin
          if (wstrb_i[b]) begin
            mtimecmp[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid_i && arready_o) begin
      case (araddr_i[15:0])
        mtime_off:    rdata_o <= mtime;
        mtimecmp_off: rdata_o <= mtimecmp;
        default:      rdata_o <= '0;  // unmapped offsets read zero
      endcase
    end
  end

  // requests on this link lie in the clint window
  a_ar_window: assert property (@(posedge clock) disable iff (reset)
    arvalid_i |-> araddr_i >= clint_base && araddr_i <= clint_last);

  a_aw_window: assert property (@(posedge clock) disable iff (reset)
    awvalid_i |-> awaddr_i >= clint_base && awaddr_i <= clint_last);

endmodule

/* axi_sram.sv */
`timescale 1ns/1ps

module axi_sram #(
  parameter int mem_words = 1024
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  core_bus_pkg::addr_t araddr_i,
  input  core_bus_pkg::id_t   arid_i,
  input  core_bus_pkg::len_t  arlen_i,
  input  logic [2:0]          arsize_i,
  input  logic [1:0]          arburst_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output core_bus_pkg::data_t rdata_o,
  output core_bus_pkg::resp_t rresp_o,
  output core_bus_pkg::id_t   rid_o,
  output logic                rlast_o,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  core_bus_pkg::addr_t awaddr_i,
  input  core_bus_pkg::id_t   awid_i,
  input  core_bus_pkg::len_t  awlen_i,
  input  logic [2:0]          awsize_i,
  input  logic [1:0]          awburst_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  core_bus_pkg::data_t wdata_i,
  input  core_bus_pkg::strb_t wstrb_i,
  input  logic                wlast_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output core_bus_pkg::resp_t bresp_o,
  output core_bus_pkg::id_t   bid_o
);

  import core_bus_pkg::*;

  localparam logic [1:0] burst_incr = 2'b01;
  localparam int         idx_w      = $clog2(mem_words);

  typedef enum logic [1:0] {s_idle, s_read, s_wdata, s_wresp} state_t;

  state_t           state;
  addr_t            addr_q;  // address of the current beat
  id_t              id_q;
  len_t             len_q;
  len_t             beat_q;
  logic [idx_w-1:0] word_idx;
  logic             last_beat;
  data_t            mem [mem_words];

  assign word_idx  = idx_w'((addr_q >> 3) % addr_t'(mem_words));
  assign last_beat = beat_q == len_q;
  assign arready_o = state == s_idle;
  assign awready_o = (state == s_idle) && !arvalid_i;  // read wins a tie
  assign rvalid_o  = state == s_read;
  assign rdata_o   = mem[word_idx];
  assign rresp_o   = resp_okay;
  assign rid_o     = id_q;
  assign rlast_o   = rvalid_o && last_beat;
  assign wready_o  = state == s_wdata;
  assign bvalid_o  = state == s_wresp;
  assign bresp_o   = resp_okay;
  assign bid_o     = id_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (arvalid_i) begin
            state <= s_read;
          end else if (awvalid_i) begin
            state <= s_wdata;
          end
        end
        s_read: begin
          if (rready_i && last_beat) begin
            state <= s_idle;
          end
        end
        s_wdata: begin
          if (wvalid_i && wlast_i) begin
            state <= s_wresp;
          end
        end
        default: begin
          if (bready_i) begin
            state <= s_idle;
          end
        end
      endcase
    end
  end

  // burst bookkeeping and the memory array itself
  always_ff @(posedge clock) begin
    if (state == s_idle) begin
      addr_q <= arvalid_i ? araddr_i : awaddr_i;
      id_q   <= arvalid_i ? arid_i : awid_i;
      len_q  <= arvalid_i ? arlen_i : awlen_i;
      beat_q <= '0;
    end else if ((rvalid_o && rready_i) || (wvalid_i && wready_o)) begin
      addr_q <= addr_q + 32'd8;
      beat_q <= beat_q + 8'd1;
    end
    if (wvalid_i && wready_o) begin
      for (int b = 0; b < 8; b++) begin
        if (wstrb_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // full-width incr bursts only, so the address steps 8 bytes per beat
  a_ar_incr: assert property (@(posedge clock) disable iff (reset)
    arvalid_i && arready_o |-> arburst_i == burst_incr && arsize_i == 3'd3);

  a_aw_incr: assert property (@(posedge clock) disable iff (reset)
    awvalid_i && awready_o |-> awburst_i == burst_incr && awsize_i == 3'd3);

endmodule

/* soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top #(
  parameter int mem_words = 1024
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                ifu_arvalid_i, ifu_rready_i,
  output logic                ifu_arready_o, ifu_rvalid_o, ifu_rlast_o,
  input  core_bus_pkg::addr_t ifu_araddr_i,
  input  core_bus_pkg::id_t   ifu_arid_i,
  input  core_bus_pkg::len_t  ifu_arlen_i,
  input  logic [2:0]          ifu_arsize_i,
  input  logic [1:0]          ifu_arburst_i,
  output core_bus_pkg::data_t ifu_rdata_o,
  output core_bus_pkg::resp_t ifu_rresp_o,
  output core_bus_pkg::id_t   ifu_rid_o,
  input  logic                exu_arvalid_i, exu_rready_i,
  output logic                exu_arready_o, exu_rvalid_o, exu_rlast_o,
  input  core_bus_pkg::addr_t exu_araddr_i, exu_awaddr_i,
  input  core_bus_pkg::id_t   exu_arid_i, exu_awid_i,
  input  core_bus_pkg::len_t  exu_arlen_i, exu_awlen_i,
  input  logic [2:0]          exu_arsize_i, exu_awsize_i,
  input  logic [1:0]          exu_arburst_i, exu_awburst_i,
  output core_bus_pkg::data_t exu_rdata_o,
  output core_bus_pkg::resp_t exu_rresp_o, exu_bresp_o,
  output core_bus_pkg::id_t   exu_rid_o, exu_bid_o,
  input  logic                exu_awvalid_i, exu_wvalid_i, exu_wlast_i, exu_bready_i,
  output logic                exu_awready_o, exu_wready_o, exu_bvalid_o,
  input  core_bus_pkg::data_t exu_wdata_i,
  input  core_bus_pkg::strb_t exu_wstrb_i,
  output logic                timer_irq_o
);

  import core_bus_pkg::*;

  // shared axi4 port, arbiter to sram
  logic       m_arvalid, m_arready, m_rvalid, m_rready, m_rlast;
  logic       m_awvalid, m_awready, m_wvalid, m_wready, m_wlast, m_bvalid, m_bready;
  addr_t      m_araddr, m_awaddr;
  id_t        m_arid, m_awid, m_rid, m_bid;
  len_t       m_arlen, m_awlen;
  logic [2:0] m_arsize, m_awsize;
  logic [1:0] m_arburst, m_awburst;
  data_t      m_rdata, m_wdata;
  strb_t      m_wstrb;
  resp_t      m_rresp, m_bresp;

  // reduced link to the clint
  logic       clint_arvalid, clint_arready, clint_rvalid, clint_rready;
  logic       clint_awvalid, clint_awready, clint_wvalid, clint_wready;
  logic       clint_bvalid, clint_bready;
  addr_t      clint_araddr, clint_awaddr;
  data_t      clint_rdata, clint_wdata;
  strb_t      clint_wstrb;
  resp_t      clint_rresp;

  bus_arbiter u_arbiter (
    .*,  // clock, reset and the ifu/exu ports by name
    .m_arvalid_o(m_arvalid), .m_arready_i(m_arready), .m_araddr_o(m_araddr),
    .m_arid_o(m_arid), .m_arlen_o(m_arlen), .m_arsize_o(m_arsize),
    .m_arburst_o(m_arburst), .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
    .m_rdata_i(m_rdata), .m_rresp_i(m_rresp), .m_rid_i(m_rid), .m_rlast_i(m_rlast),
    .m_awvalid_o(m_awvalid), .m_awready_i(m_awready), .m_awaddr_o(m_awaddr),
    .m_awid_o(m_awid), .m_awlen_o(m_awlen), .m_awsize_o(m_awsize),
    .m_awburst_o(m_awburst), .m_wvalid_o(m_wvalid), .m_wready_i(m_wready),
    .m_wdata_o(m_wdata), .m_wstrb_o(m_wstrb), .m_wlast_o(m_wlast),
    .m_bvalid_i(m_bvalid), .m_bready_o(m_bready), .m_bresp_i(m_bresp), .m_bid_i(m_bid),
    .clint_arvalid_o(clint_arvalid), .clint_arready_i(clint_arready),
    .clint_araddr_o(clint_araddr), .clint_rvalid_i(clint_rvalid),
    .clint_rready_o(clint_rready), .clint_rdata_i(clint_rdata),
    .clint_rresp_i(clint_rresp), .clint_awvalid_o(clint_awvalid),
    .clint_awready_i(clint_awready), .clint_awaddr_o(clint_awaddr),
    .clint_wvalid_o(clint_wvalid), .clint_wready_i(clint_wready),
    .clint_wdata_o(clint_wdata), .clint_wstrb_o(clint_wstrb),
    .clint_bvalid_i(clint_bvalid), .clint_bready_o(clint_bready)
  );

  clint u_clint (
    .clock(clock), .reset(reset),
    .arvalid_i(clint_arvalid), .arready_o(clint_arready), .araddr_i(clint_araddr),
    .rvalid_o(clint_rvalid), .rready_i(clint_rready), .rdata_o(clint_rdata),
    .rresp_o(clint_rresp), .awvalid_i(clint_awvalid), .awready_o(clint_awready),
    .awaddr_i(clint_awaddr), .wvalid_i(clint_wvalid), .wready_o(clint_wready),
    .wdata_i(clint_wdata), .wstrb_i(clint_wstrb), .bvalid_o(clint_bvalid),
    .bready_i(clint_bready), .timer_irq_o(timer_irq_o)
  );

  axi_sram #(.mem_words(mem_words)) u_sram (
    .clock(clock), .reset(reset),
    .arvalid_i(m_arvalid), .arready_o(m_arready), .araddr_i(m_araddr),
    .arid_i(m_arid), .arlen_i(m_arlen), .arsize_i(m_arsize), .arburst_i(m_arburst),
    .rvalid_o(m_rvalid), .rready_i(m_rready), .rdata_o(m_rdata),
    .rresp_o(m_rresp), .rid_o(m_rid), .rlast_o(m_rlast),
    .awvalid_i(m_awvalid), .awready_o(m_awready), .awaddr_i(m_awaddr),
    .awid_i(m_awid), .awlen_i(m_awlen), .awsize_i(m_awsize), .awburst_i(m_awburst),
    .wvalid_i(m_wvalid), .wready_o(m_wready), .wdata_i(m_wdata),
    .wstrb_i(m_wstrb), .wlast_i(m_wlast),
    .bvalid_o(m_bvalid), .bready_i(m_bready), .bresp_o(m_bresp), .bid_o(m_bid)
  );

endmodule

/* tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;

  import core_bus_pkg::*;

  localparam int mem_words   = 1024;
  localparam int num_tests   = 9;
  localparam int reset_len   = 4;
  localparam int cycle_limit = num_tests * 64 + reset_len;
  localparam int gap_cycles  = 10;  // idle cycles between the two mtime reads

  typedef enum logic [1:0] {op_burst, op_race, op_mtime, op_cmp} op_t;

  typedef struct packed {
    logic  exu;     // master, else ifu
    op_t   op;
    addr_t addr;
    len_t  len;
    strb_t strb;
    logic  seeded;  // burst write with xorshift data, else read against ref_mem
    logic  stall;   // toggle rready
  } test_t;

  logic clock = 1'b0;
  logic reset;
  logic ifu_arvalid_i, ifu_rready_i, ifu_arready_o, ifu_rvalid_o, ifu_rlast_o;
  addr_t ifu_araddr_i;
  id_t ifu_arid_i, ifu_rid_o;
  len_t ifu_arlen_i;
  logic [2:0] ifu_arsize_i, exu_arsize_i, exu_awsize_i;
  logic [1:0] ifu_arburst_i, exu_arburst_i, exu_awburst_i;
  data_t ifu_rdata_o, exu_rdata_o, exu_wdata_i;
  resp_t ifu_rresp_o, exu_rresp_o, exu_bresp_o;
  logic exu_arvalid_i, exu_rready_i, exu_arready_o, exu_rvalid_o, exu_rlast_o;
  addr_t exu_araddr_i, exu_awaddr_i;
  id_t exu_arid_i, exu_awid_i, exu_rid_o, exu_bid_o;
  len_t exu_arlen_i, exu_awlen_i;
  logic exu_awvalid_i, exu_wvalid_i, exu_wlast_i, exu_bready_i;
  logic exu_awready_o, exu_wready_o, exu_bvalid_o;
  strb_t exu_wstrb_i;
  logic timer_irq_o;

  test_t tests [num_tests];
  data_t ref_mem [mem_words];
  data_t last_mtime;
  logic [31:0] rng = 32'h5c19;
  int cycles = 0;
  int data_errs = 0;
  int resp_errs = 0;
  int id_errs = 0;
  int bit_errs = 0;
  int other_errs = 0;

  soc_bus_top #(.mem_words(mem_words)) DUT (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int word_of(input addr_t addr);
    return int'((addr >> 3) % addr_t'(mem_words));
  endfunction

  function automatic string op_label(input op_t op);
    case (op)
      op_burst: return "burst";
      op_race:  return "race";
      op_mtime: return "mtime";
      default:  return "mtimecmp";
    endcase
  endfunction

  task automatic next_data(output data_t d);
    rng = xorshift(rng);
    d[63:32] = rng;
    rng = xorshift(rng);
    d[31:0] = rng;
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      resp_errs++;
      $display("ERROR %s resp: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp) begin
      id_errs++;
      $display("ERROR %s id: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("errors: data %0d, resp %0d, id %0d, bit %0d, other %0d",
             data_errs, resp_errs, id_errs, bit_errs, other_errs);
  endtask

  task automatic write_burst(input string name, input addr_t addr, input len_t len,
                             input strb_t strb, input id_t id);
    data_t d;
    int w;
    @(negedge clock);
    exu_awvalid_i = 1'b1;
    exu_awaddr_i  = addr;
    exu_awid_i    = id;
    exu_awlen_i   = len;
    #2;
    while (!exu_awready_o) begin
      @(negedge clock);
      #2;
    end
    @(negedge clock);
    exu_awvalid_i = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      next_data(d);
      exu_wvalid_i = 1'b1;
      exu_wdata_i  = d;
      exu_wstrb_i  = strb;
      exu_wlast_i  = k == int'(len);
      #2;
      while (!exu_wready_o) begin
        @(negedge clock);
        #2;
      end
      w = word_of(addr + addr_t'(8 * k));
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          ref_mem[w][8*b +: 8] = d[8*b +: 8];
        end
      end
      @(negedge clock);
    end
    exu_wvalid_i = 1'b0;
    exu_wlast_i  = 1'b0;
    exu_bready_i = 1'b1;
    #2;
    while (!exu_bvalid_o) begin
      @(negedge clock);
      #2;
    end
    check_resp(name, resp_okay, exu_bresp_o);
    check_id(name, id, exu_bid_o);
    @(negedge clock);
    exu_bready_i = 1'b0;
  endtask

  task automatic read_burst(input string name, input logic exu, input addr_t addr,
                            input len_t len, input id_t id, input logic stall);
    int beat;
    int phase;
    string beat_name;
    @(negedge clock);
    exu_arvalid_i = exu;
    ifu_arvalid_i = !exu;
    exu_araddr_i  = addr;
    ifu_araddr_i  = addr;
    exu_arid_i    = id;
    ifu_arid_i    = id;
    exu_arlen_i   = len;
    ifu_arlen_i   = len;
    #2;
    while (!(exu ? exu_arready_o : ifu_arready_o)) begin
      @(negedge clock);
      #2;
    end
    @(negedge clock);
    exu_arvalid_i = 1'b0;
    ifu_arvalid_i = 1'b0;
    beat = 0;
    phase = 0;
    while (beat <= int'(len)) begin
      exu_rready_i = exu && (!stall || phase[0]);  // every other cycle when stalling
      ifu_rready_i = !exu;
      phase++;
      #2;
      if (!exu) begin
        check_bit({name, " exu rvalid"}, 1'b0, exu_rvalid_o);
      end
      if (exu ? (exu_rvalid_o && exu_rready_i) : (ifu_rvalid_o && ifu_rready_i)) begin
        beat_name = $sformatf("%s beat %0d", name, beat);
        check_data(beat_name, ref_mem[word_of(addr + addr_t'(8 * beat))],
                   exu ? exu_rdata_o : ifu_rdata_o);
        check_resp(beat_name, resp_okay, exu ? exu_rresp_o : ifu_rresp_o);
        check_id(beat_name, id, exu ? exu_rid_o : ifu_rid_o);
        check_bit({beat_name, " rlast"}, beat == int'(len), exu ? exu_rlast_o : ifu_rlast_o);
        beat++;
      end
      @(negedge clock);
    end
    exu_rready_i = 1'b0;
    ifu_rready_i = 1'b0;
  endtask

  // both masters request in the same cycle, exu must finish first
  task automatic race_reads(input string name, input addr_t addr, input len_t len,
                            input id_t id);
    logic exu_done;
    logic ifu_done;
    logic exu_ar_hs;
    logic ifu_ar_hs;
    @(negedge clock);
    exu_arvalid_i = 1'b1;
    exu_araddr_i  = addr;
    exu_arid_i    = id;
    exu_arlen_i   = len;
    ifu_arvalid_i = 1'b1;
    ifu_araddr_i  = addr;
    ifu_arid_i    = id;
    ifu_arlen_i   = len;
    exu_rready_i  = 1'b1;
    ifu_rready_i  = 1'b1;
    exu_done = 1'b0;
    ifu_done = 1'b0;
    while (!ifu_done) begin
      #2;
      exu_ar_hs = exu_arready_o;
      ifu_ar_hs = ifu_arready_o;
      if (!exu_done && ifu_arready_o) begin
        other_errs++;
        $display("%s: ifu address was accepted before the exu read finished", name);
      end
      if (exu_rvalid_o && exu_rlast_o) begin
        exu_done = 1'b1;
      end
      if (ifu_rvalid_o && ifu_rlast_o) begin
        ifu_done = 1'b1;
      end
      @(negedge clock);
      if (exu_ar_hs) begin
        exu_arvalid_i = 1'b0;
      end
      if (ifu_ar_hs) begin
        ifu_arvalid_i = 1'b0;
      end
    end
    exu_rready_i = 1'b0;
    ifu_rready_i = 1'b0;
  endtask

  task automatic read_clint(input string name, input addr_t addr, input id_t id,
                            output data_t value);
    @(negedge clock);
    exu_arvalid_i = 1'b1;
    exu_araddr_i  = addr;
    exu_arid_i    = id;
    exu_arlen_i   = '0;
    exu_rready_i  = 1'b1;
    #2;
    while (!exu_arready_o) begin
      @(negedge clock);
      #2;
    end
    check_bit({name, " shared arvalid"}, 1'b0, DUT.m_arvalid);
    @(negedge clock);
    exu_arvalid_i = 1'b0;
    #2;
    while (!exu_rvalid_o) begin
      @(negedge clock);
      #2;
    end
    value = exu_rdata_o;
    check_bit({name, " rlast"}, 1'b1, exu_rlast_o);
    check_resp(name, resp_okay, exu_rresp_o);
    check_id(name, id, exu_rid_o);
    check_bit({name, " shared rvalid"}, 1'b0, DUT.m_rvalid);
    @(negedge clock);
    exu_rready_i = 1'b0;
  endtask

  task automatic write_clint(input string name, input addr_t addr, input id_t id,
                             input data_t value);
    @(negedge clock);
    exu_awvalid_i = 1'b1;  // aw and w together
    exu_awaddr_i  = addr;
    exu_awid_i    = id;
    exu_awlen_i   = '0;
    exu_wvalid_i  = 1'b1;
    exu_wdata_i   = value;
    exu_wstrb_i   = '1;
    exu_wlast_i   = 1'b1;
    exu_bready_i  = 1'b1;
    #2;
    while (!(exu_awready_o && exu_wready_o)) begin
      @(negedge clock);
      #2;
    end
    @(negedge clock);
    exu_awvalid_i = 1'b0;
    exu_wvalid_i  = 1'b0;
    exu_wlast_i   = 1'b0;
    #2;
    while (!exu_bvalid_o) begin
      @(negedge clock);
      #2;
    end
    check_resp(name, resp_okay, exu_bresp_o);
    check_id(name, id, exu_bid_o);
    @(negedge clock);
    exu_bready_i = 1'b0;
  endtask

  task automatic mtime_gap(input string name, input addr_t addr, input id_t id);
    data_t t0;
    data_t t1;
    read_clint(name, addr, id, t0);
    repeat (gap_cycles) @(negedge clock);
    read_clint(name, addr, id, t1);
    if (t1 - t0 < data_t'(gap_cycles)) begin
      other_errs++;
      $display("%s: mtime moved from %0d to %0d, less than the gap", name, t0, t1);
    end
    last_mtime = t1;
  endtask

  task automatic mtimecmp_check(input string name, input addr_t addr, input id_t id);
    data_t cmp;
    data_t back;
    int waited;
    cmp = last_mtime + 64'd40;  // a little ahead of mtime
    write_clint(name, addr, id, cmp);
    check_bit({name, " irq before compare"}, 1'b0, timer_irq_o);
    read_clint(name, addr, id, back);
    check_data({name, " readback"}, cmp, back);
    waited = 0;
    while (!timer_irq_o && waited < 64) begin
      @(negedge clock);
      waited++;
    end
    if (!timer_irq_o) begin
      other_errs++;
      $display("%s: timer interrupt did not rise within 64 cycles", name);
    end
    write_clint(name, addr, id, '1);
    check_bit({name, " irq cleared"}, 1'b0, timer_irq_o);
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      other_errs++;
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    test_t t;
    string name;
    id_t id;
    reset = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_rready_i  = 1'b0;
    ifu_araddr_i  = '0;
    ifu_arid_i    = '0;
    ifu_arlen_i   = '0;
    ifu_arsize_i  = 3'd3;  // full 64-bit beats
    ifu_arburst_i = 2'b01;  // incr
    exu_arvalid_i = 1'b0;
    exu_rready_i  = 1'b0;
    exu_araddr_i  = '0;
    exu_arid_i    = '0;
    exu_arlen_i   = '0;
    exu_arsize_i  = 3'd3;
    exu_arburst_i = 2'b01;
    exu_awvalid_i = 1'b0;
    exu_awaddr_i  = '0;
    exu_awid_i    = '0;
    exu_awlen_i   = '0;
    exu_awsize_i  = 3'd3;
    exu_awburst_i = 2'b01;
    exu_wvalid_i  = 1'b0;
    exu_wdata_i   = '0;
    exu_wstrb_i   = '0;
    exu_wlast_i   = 1'b0;
    exu_bready_i  = 1'b0;

    tests[0] = '{1'b1, op_burst, 32'h0000_0100, 8'd3, 8'hff, 1'b1, 1'b0};
    tests[1] = '{1'b1, op_burst, 32'h0000_0100, 8'd3, 8'h5a, 1'b1, 1'b0};  // partial bytes
    tests[2] = '{1'b1, op_burst, 32'h0000_0100, 8'd3, 8'h00, 1'b0, 1'b0};
    tests[3] = '{1'b0, op_burst, 32'h0000_0100, 8'd3, 8'h00, 1'b0, 1'b0};
    tests[4] = '{1'b1, op_race, 32'h0000_0100, 8'd3, 8'h00, 1'b0, 1'b0};
    tests[5] = '{1'b1, op_mtime, clint_base + addr_t'(mtime_off), 8'd0, 8'h00, 1'b0, 1'b0};
    tests[6] = '{1'b1, op_cmp, clint_base + addr_t'(mtimecmp_off), 8'd0, 8'hff, 1'b0, 1'b0};
    tests[7] = '{1'b1, op_burst, 32'h0000_0400, 8'd7, 8'hff, 1'b1, 1'b0};
    tests[8] = '{1'b1, op_burst, 32'h0000_0400, 8'd7, 8'h00, 1'b0, 1'b1};

    repeat (reset_len) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #2;
    check_bit("reset timer_irq", 1'b0, timer_irq_o);
    check_bit("reset exu_arready", 1'b0, exu_arready_o);
    check_bit("reset sram arready", 1'b1, DUT.m_arready);

    for (int i = 0; i < num_tests; i++) begin
      t = tests[i];
      name = $sformatf("t%0d_%s_%s", i, t.exu ? "exu" : "ifu", op_label(t.op));
      id = id_t'(i);
      case (t.op)
        op_burst: begin
          if (t.seeded) begin
            write_burst(name, t.addr, t.len, t.strb, id);
          end else begin
            read_burst(name, t.exu, t.addr, t.len, id, t.stall);
          end
        end
        op_race:  race_reads(name, t.addr, t.len, id);
        op_mtime: mtime_gap(name, t.addr, id);
        default:  mtimecmp_check(name, t.addr, id);
      endcase
    end

    print_counts();
    if (data_errs + resp_errs + id_errs + bit_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* project.f */
core_bus_pkg.sv
bus_arbiter.sv
clint.sv
axi_sram.sv
soc_bus_top.sv
tb_soc_bus.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_soc_bus
FLIST = project.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
